// ==== logic/rv_isa_pkg.sv ====
package rv_isa_pkg;

  // ####################
  // Opcodes and funct3
  // ####################
  typedef enum logic [6:0] {
    op_lui    = 7'b0110111,
    op_auipc  = 7'b0010111,
    op_jal    = 7'b1101111,
    op_jalr   = 7'b1100111,
    op_branch = 7'b1100011,
    op_imm    = 7'b0010011,
    op_reg    = 7'b0110011
  } opcode_e;

  localparam logic [2:0] f3_add  = 3'b000;  // Also sub.
  localparam logic [2:0] f3_sll  = 3'b001;
  localparam logic [2:0] f3_slt  = 3'b010;
  localparam logic [2:0] f3_sltu = 3'b011;
  localparam logic [2:0] f3_xor  = 3'b100;
  localparam logic [2:0] f3_sr   = 3'b101;  // Logical or arithmetic by funct7.
  localparam logic [2:0] f3_or   = 3'b110;
  localparam logic [2:0] f3_and  = 3'b111;

  localparam logic [2:0] f3_beq  = 3'b000;
  localparam logic [2:0] f3_bne  = 3'b001;
  localparam logic [2:0] f3_blt  = 3'b100;
  localparam logic [2:0] f3_bge  = 3'b101;
  localparam logic [2:0] f3_bltu = 3'b110;
  localparam logic [2:0] f3_bgeu = 3'b111;

  // ####################
  // ALU control
  // ####################
  typedef enum logic [3:0] {
    alu_add, alu_sub, alu_sll, alu_slt,
    alu_sltu, alu_xor, alu_srl, alu_sra,
    alu_or, alu_and, alu_pass_b
  } alu_op_e;

  // How the ALU output becomes the stage result.
  typedef enum logic [1:0] {
    set_res,
    set_is_zero,
    set_not_zero,
    set_lsb_clear
  } alu_set_e;

  // ####################
  // Instruction formats
  // ####################
  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } r_t;

  typedef struct packed {
    logic [11:0] imm_11_0;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } i_t;

  typedef struct packed {
    logic [6:0] imm_11_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] imm_4_0;
    logic [6:0] opcode;
  } s_t;

  typedef struct packed {
    logic       imm_12;
    logic [5:0] imm_10_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [3:0] imm_4_1;
    logic       imm_11;
    logic [6:0] opcode;
  } b_t;

  typedef struct packed {
    logic [19:0] imm_31_12;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } u_t;

  typedef struct packed {
    logic       imm_20;
    logic [9:0] imm_10_1;
    logic       imm_11;
    logic [7:0] imm_19_12;
    logic [4:0] rd;
    logic [6:0] opcode;
  } j_t;

  typedef union packed {
    r_t r;
    i_t i;
    s_t s;
    b_t b;
    u_t u;
    j_t j;
  } inst_u;

endpackage

// ==== logic/pipe_pkg.sv ====
package pipe_pkg;

  localparam int xlen = 32;
  localparam logic [xlen-1:0] pc_step = 4;  // One instruction word.

  // Handshake states, one set per stage.
  typedef enum logic [1:0] {st_idle, st_exec, st_wait} stage_e;

  typedef struct packed {
    logic [xlen-1:0] pc;
    logic [xlen-1:0] inst;
    logic [xlen-1:0] rs1_data;
    logic [xlen-1:0] rs2_data;
  } fetch_t;

  typedef struct packed {
    logic [xlen-1:0]     pc;
    logic [xlen-1:0]     alu_src1;
    logic [xlen-1:0]     alu_src2;
    rv_isa_pkg::alu_op_e  alu_op;
    rv_isa_pkg::alu_set_e alu_set;
    logic [4:0]          rd_addr;
    logic                wb;
    logic                branch;
    logic                jump;
    logic [xlen-1:0]     target;
  } dec_t;

  typedef struct packed {
    logic [xlen-1:0] pc;
    logic [xlen-1:0] target;
    logic [xlen-1:0] alu_res;
    logic [4:0]      rd_addr;
    logic            wb;
    logic            jump;
    logic            branch_taken;
  } exe_t;

  typedef struct packed {
    logic [xlen-1:0] pc;
    logic [xlen-1:0] next_pc;
    logic [xlen-1:0] wdata;
    logic [4:0]      rd_addr;
    logic            wb;
  } retire_t;

endpackage

// ==== logic/alu.sv ====
`timescale 1ns/1ps

module alu (
  input  logic [pipe_pkg::xlen-1:0] src1,
  input  logic [pipe_pkg::xlen-1:0] src2,
  input  rv_isa_pkg::alu_op_e       ctrl,
  output logic [pipe_pkg::xlen-1:0] alu_out,
  output logic                      not_zero
);

  logic [4:0] shamt;

  assign shamt = src2[4:0];

  always_comb begin
    case (ctrl)
      rv_isa_pkg::alu_add:    alu_out = src1 + src2;
      rv_isa_pkg::alu_sub:    alu_out = src1 - src2;
      rv_isa_pkg::alu_sll:    alu_out = src1 << shamt;
      rv_isa_pkg::alu_slt:    alu_out = {{(pipe_pkg::xlen-1){1'b0}}, $signed(src1) < $signed(src2)};
      rv_isa_pkg::alu_sltu:   alu_out = {{(pipe_pkg::xlen-1){1'b0}}, src1 < src2};
      rv_isa_pkg::alu_xor:    alu_out = src1 ^ src2;
      rv_isa_pkg::alu_srl:    alu_out = src1 >> shamt;
      rv_isa_pkg::alu_sra:    alu_out = $signed(src1) >>> shamt;  // Sign fill.
      rv_isa_pkg::alu_or:     alu_out = src1 | src2;
      rv_isa_pkg::alu_and:    alu_out = src1 & src2;
      rv_isa_pkg::alu_pass_b: alu_out = src2;
      default:                alu_out = '0;
    endcase
  end

  assign not_zero = |alu_out;

endmodule

// ==== logic/idu.sv ====
`timescale 1ns/1ps

module idu (
  input  logic             clock,
  input  logic             reset,
  input  pipe_pkg::fetch_t fetch,
  input  logic             fetch_valid,
  output logic             fetch_ready,
  output pipe_pkg::dec_t   dec,
  output logic             dec_valid,
  input  logic             dec_ready
);

  pipe_pkg::stage_e state, next;
  rv_isa_pkg::inst_u inst;
  pipe_pkg::dec_t dec_next;
  logic [pipe_pkg::xlen-1:0] imm_i, imm_u, imm_b, imm_j;
  logic [pipe_pkg::xlen-1:0] jalr_sum;

  function automatic rv_isa_pkg::alu_op_e alu_op_of(input logic [2:0] funct3,
                                                    input logic alt);
    unique case (funct3)
      rv_isa_pkg::f3_add:  alu_op_of = alt ? rv_isa_pkg::alu_sub : rv_isa_pkg::alu_add;
      rv_isa_pkg::f3_sll:  alu_op_of = rv_isa_pkg::alu_sll;
      rv_isa_pkg::f3_slt:  alu_op_of = rv_isa_pkg::alu_slt;
      rv_isa_pkg::f3_sltu: alu_op_of = rv_isa_pkg::alu_sltu;
      rv_isa_pkg::f3_xor:  alu_op_of = rv_isa_pkg::alu_xor;
      rv_isa_pkg::f3_sr:   alu_op_of = alt ? rv_isa_pkg::alu_sra : rv_isa_pkg::alu_srl;
      rv_isa_pkg::f3_or:   alu_op_of = rv_isa_pkg::alu_or;
      rv_isa_pkg::f3_and:  alu_op_of = rv_isa_pkg::alu_and;
    endcase
  endfunction

  assign inst = fetch.inst;

  // ####################
  // Immediates
  // ####################
  assign imm_i = {{20{inst.i.imm_11_0[11]}}, inst.i.imm_11_0};
  assign imm_u = {inst.u.imm_31_12, 12'b0};
  assign imm_b = {{19{inst.b.imm_12}}, inst.b.imm_12, inst.b.imm_11,
                  inst.b.imm_10_5, inst.b.imm_4_1, 1'b0};
  assign imm_j = {{11{inst.j.imm_20}}, inst.j.imm_20, inst.j.imm_19_12,
                  inst.j.imm_11, inst.j.imm_10_1, 1'b0};
  assign jalr_sum = fetch.rs1_data + imm_i;

  // ####################
  // Decode
  // ####################
  always_comb begin
    dec_next          = '0;
    dec_next.pc       = fetch.pc;
    dec_next.alu_src1 = fetch.rs1_data;
    dec_next.alu_src2 = fetch.rs2_data;
    dec_next.alu_op   = rv_isa_pkg::alu_add;
    dec_next.alu_set  = rv_isa_pkg::set_res;
    dec_next.rd_addr  = inst.r.rd;
    dec_next.target   = fetch.pc + imm_b;
    case (inst.r.opcode)
      rv_isa_pkg::op_reg: begin
        dec_next.alu_op = alu_op_of(inst.r.funct3, inst.r.funct7[5]);
        dec_next.wb     = 1'b1;
      end
      rv_isa_pkg::op_imm: begin
        dec_next.alu_src2 = imm_i;
        // Only srai carries the funct7 flag, addi has no subtract form.
        dec_next.alu_op   = alu_op_of(inst.i.funct3,
                                      inst.i.funct3 == rv_isa_pkg::f3_sr && inst.r.funct7[5]);
        dec_next.wb       = 1'b1;
      end
      rv_isa_pkg::op_lui: begin
        dec_next.alu_src2 = imm_u;
        dec_next.alu_op   = rv_isa_pkg::alu_pass_b;
        dec_next.wb       = 1'b1;
      end
      rv_isa_pkg::op_auipc: begin
        dec_next.alu_src1 = fetch.pc;
        dec_next.alu_src2 = imm_u;
        dec_next.wb       = 1'b1;
      end
      rv_isa_pkg::op_jal, rv_isa_pkg::op_jalr: begin
        dec_next.alu_src1 = fetch.pc;  // Link value pc+4.
        dec_next.alu_src2 = pipe_pkg::pc_step;
        dec_next.jump     = 1'b1;
        dec_next.wb       = 1'b1;
        if (inst.r.opcode == rv_isa_pkg::op_jal) dec_next.target = fetch.pc + imm_j;
        else dec_next.target = {jalr_sum[pipe_pkg::xlen-1:1], 1'b0};
      end
      rv_isa_pkg::op_branch: begin
        dec_next.branch = 1'b1;
        case (inst.b.funct3)
          rv_isa_pkg::f3_beq: begin
            dec_next.alu_op  = rv_isa_pkg::alu_sub;
            dec_next.alu_set = rv_isa_pkg::set_is_zero;
          end
          rv_isa_pkg::f3_bne: begin
            dec_next.alu_op  = rv_isa_pkg::alu_sub;
            dec_next.alu_set = rv_isa_pkg::set_not_zero;
          end
          rv_isa_pkg::f3_blt: dec_next.alu_op = rv_isa_pkg::alu_slt;
          rv_isa_pkg::f3_bge: begin
            dec_next.alu_op  = rv_isa_pkg::alu_slt;
            dec_next.alu_set = rv_isa_pkg::set_lsb_clear;
          end
          rv_isa_pkg::f3_bltu: dec_next.alu_op = rv_isa_pkg::alu_sltu;
          rv_isa_pkg::f3_bgeu: begin
            dec_next.alu_op  = rv_isa_pkg::alu_sltu;
            dec_next.alu_set = rv_isa_pkg::set_lsb_clear;
          end
          default: dec_next.branch = 1'b0;  // Reserved funct3 never branches.
        endcase
      end
      default: ;  // Unknown opcode retires as a no-op.
    endcase
    if (!dec_next.wb) dec_next.rd_addr = '0;
  end

  // ####################
  // Handshake
  // ####################
  always_comb begin
    case (state)
      pipe_pkg::st_idle: next = fetch_valid ? pipe_pkg::st_exec : pipe_pkg::st_idle;
      default:           next = dec_ready ? pipe_pkg::st_idle : pipe_pkg::st_wait;
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      state       <= pipe_pkg::st_idle;
      fetch_ready <= 1'b1;
      dec_valid   <= 1'b0;
    end else begin
      state       <= next;
      fetch_ready <= next == pipe_pkg::st_idle;
      dec_valid   <= next != pipe_pkg::st_idle;
    end
  end

  always_ff @(posedge clock) begin
    if (state == pipe_pkg::st_idle && fetch_valid) dec <= dec_next;
  end

endmodule

// ==== logic/exu.sv ====
`timescale 1ns/1ps

module exu (
  input  logic           clock,
  input  logic           reset,
  input  pipe_pkg::dec_t dec,
  input  logic           dec_valid,
  output logic           dec_ready,
  output pipe_pkg::exe_t exe,
  output logic           exe_valid,
  input  logic           exe_ready
);

  pipe_pkg::stage_e state, next;
  logic [pipe_pkg::xlen-1:0] alu_out;
  logic [pipe_pkg::xlen-1:0] alu_res;
  logic not_zero;
  logic taken;

  alu u_alu (
    .src1     (dec.alu_src1),
    .src2     (dec.alu_src2),
    .ctrl     (dec.alu_op),
    .alu_out  (alu_out),
    .not_zero (not_zero)
  );

  // ####################
  // Handshake FSM
  // ####################
  always_comb begin
    case (state)
      pipe_pkg::st_idle: next = dec_valid ? pipe_pkg::st_exec : pipe_pkg::st_idle;
      default:           next = exe_ready ? pipe_pkg::st_idle : pipe_pkg::st_wait;
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      state     <= pipe_pkg::st_idle;
      dec_ready <= 1'b1;
      exe_valid <= 1'b0;
    end else begin
      state     <= next;
      dec_ready <= next == pipe_pkg::st_idle;  // Ready only with an empty slot.
      exe_valid <= next != pipe_pkg::st_idle;
    end
  end

  // ####################
  // Result select
  // ####################
  always_comb begin
    unique case (dec.alu_set)
      rv_isa_pkg::set_res:       alu_res = alu_out;
      rv_isa_pkg::set_is_zero:   alu_res = {{(pipe_pkg::xlen-1){1'b0}}, ~not_zero};
      rv_isa_pkg::set_not_zero:  alu_res = {{(pipe_pkg::xlen-1){1'b0}}, not_zero};
      rv_isa_pkg::set_lsb_clear: alu_res = {{(pipe_pkg::xlen-1){1'b0}}, ~alu_out[0]};
    endcase
  end

  // Condition lands in bit 0 for every branch form.
  assign taken = dec.branch & alu_res[0];

  always_ff @(posedge clock) begin
    if (state == pipe_pkg::st_idle && dec_valid) begin
      exe.pc           <= dec.pc;
      exe.target       <= dec.target;
      exe.alu_res      <= alu_res;
      exe.rd_addr      <= dec.rd_addr;
      exe.wb           <= dec.wb;
      exe.jump         <= dec.jump;
      exe.branch_taken <= taken;
    end
  end

endmodule

// ==== logic/commit_unit.sv ====
`timescale 1ns/1ps

module commit_unit (
  input  logic              clock,
  input  logic              reset,
  input  pipe_pkg::exe_t    exe,
  input  logic              exe_valid,
  output logic              exe_ready,
  output pipe_pkg::retire_t retire,
  output logic              retire_valid,
  input  logic              retire_ready
);

  pipe_pkg::stage_e state, next;
  pipe_pkg::retire_t retire_next;

  always_comb begin
    retire_next.pc      = exe.pc;
    retire_next.rd_addr = exe.rd_addr;
    retire_next.wb      = exe.wb && exe.rd_addr != '0;  // x0 is never written.
    retire_next.wdata   = retire_next.wb ? exe.alu_res : '0;
    if (exe.jump || exe.branch_taken) retire_next.next_pc = exe.target;
    else retire_next.next_pc = exe.pc + pipe_pkg::pc_step;
  end

  // ####################
  // Handshake FSM
  // ####################
  always_comb begin
    case (state)
      pipe_pkg::st_idle: next = exe_valid ? pipe_pkg::st_exec : pipe_pkg::st_idle;
      default:           next = retire_ready ? pipe_pkg::st_idle : pipe_pkg::st_wait;
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      state        <= pipe_pkg::st_idle;
      exe_ready    <= 1'b1;
      retire_valid <= 1'b0;
    end else begin
      state        <= next;
      exe_ready    <= next == pipe_pkg::st_idle;
      retire_valid <= next != pipe_pkg::st_idle;
    end
  end

  // Held until the consumer takes it.
  always_ff @(posedge clock) begin
    if (state == pipe_pkg::st_idle && exe_valid) retire <= retire_next;
  end

endmodule

// ==== logic/rv_exec_top.sv ====
`timescale 1ns/1ps

module rv_exec_top (
  input  logic              clock,
  input  logic              reset,
  input  pipe_pkg::fetch_t  fetch,
  input  logic              fetch_valid,
  output logic              fetch_ready,
  output pipe_pkg::retire_t retire,
  output logic              retire_valid,
  input  logic              retire_ready
);

  // Stage links.
  pipe_pkg::dec_t dec;
  logic           dec_valid;
  logic           dec_ready;
  pipe_pkg::exe_t exe;
  logic           exe_valid;
  logic           exe_ready;

  idu u_idu (.*);

  exu u_exu (.*);

  commit_unit u_commit (.*);

endmodule

// ==== verif/rv_exec_assert.sv ====
`timescale 1ns/1ps

module rv_exec_assert (
  input logic              clock,
  input logic              reset,
  input logic              fetch_valid,
  input logic              fetch_ready,
  input logic              dec_valid,
  input logic              exe_valid,
  input pipe_pkg::retire_t retire,
  input logic              retire_valid,
  input logic              retire_ready
);

  int errors = 0;  // Read by the testbench.

  // Input side open and output empty once reset drops.
  reset_state: assert property (@(posedge clock) $fell(reset) |-> fetch_ready && !retire_valid)
    else begin
      errors++;
      $error("fetch_ready low or retire_valid high in the first cycle after reset");
    end

  // One-entry decode slot closes right after a transfer.
  fetch_accept: assert property (@(posedge clock) disable iff (reset)
    fetch_valid && fetch_ready |=> !fetch_ready && dec_valid)
    else begin
      errors++;
      $error("decode stage did not take the fetch packet");
    end

  // Empty pipeline gives a fixed three-cycle path.
  idle_latency: assert property (@(posedge clock) disable iff (reset)
    fetch_valid && fetch_ready && !dec_valid && !exe_valid && !retire_valid
      |-> ##3 $rose(retire_valid))
    else begin
      errors++;
      $error("retire_valid did not rise three cycles after the fetch transfer");
    end

  stall_hold: assert property (@(posedge clock) disable iff (reset)
    retire_valid && !retire_ready |=> retire_valid && $stable(retire))
    else begin
      errors++;
      $error("retire record changed or dropped while stalled");
    end

endmodule

bind rv_exec_top rv_exec_assert u_assert (.*);

// ==== verif/rv_exec_tb.sv ====
`timescale 1ns/1ps

module rv_exec_tb;

  localparam int n_inst = 300;
  localparam int max_cycles = n_inst * 8 + 50;

  logic clock = 1'b0;
  logic reset;
  pipe_pkg::fetch_t fetch;
  logic fetch_valid;
  logic fetch_ready;
  pipe_pkg::retire_t retire;
  logic retire_valid;
  logic retire_ready;

  integer seed;
  int cycles = 0;
  int retired;
  pipe_pkg::retire_t expected_q[$];  // In fetch order.

  rv_exec_top dut (.*);

  always #20 clock = ~clock;

  task automatic stop_run(input string msg);
    $display("%s", msg);
    $display("*** TEST FAILED ***");
    $fatal(1, "simulation stopped at the first error");
  endtask

  always @(posedge clock) begin
    cycles++;
    if (cycles > max_cycles)
      stop_run($sformatf("timeout after %0d cycles with %0d of %0d instructions retired",
                         max_cycles, retired, n_inst));
  end

  // ####################
  // Reference model
  // ####################
  function automatic logic [31:0] alu_calc(input logic [2:0] f3, input logic alt,
                                           input logic [31:0] x, input logic [31:0] y);
    case (f3)
      3'd0: alu_calc = alt ? x - y : x + y;
      3'd1: alu_calc = x << y[4:0];
      3'd2: alu_calc = {31'b0, $signed(x) < $signed(y)};
      3'd3: alu_calc = {31'b0, x < y};
      3'd4: alu_calc = x ^ y;
      3'd5: begin
        if (alt) alu_calc = $signed(x) >>> y[4:0];  // Sign fill.
        else alu_calc = x >> y[4:0];
      end
      3'd6: alu_calc = x | y;
      default: alu_calc = x & y;
    endcase
  endfunction

  function automatic pipe_pkg::retire_t expected_retire(input pipe_pkg::fetch_t f);
    pipe_pkg::retire_t r;
    logic [31:0] a, b, imm_i, imm_b, imm_j, imm_u, value;
    logic [2:0] f3;
    logic writes, taken;
    a      = f.rs1_data;
    b      = f.rs2_data;
    f3     = f.inst[14:12];
    imm_i  = {{20{f.inst[31]}}, f.inst[31:20]};
    imm_b  = {{20{f.inst[31]}}, f.inst[7], f.inst[30:25], f.inst[11:8], 1'b0};
    imm_j  = {{12{f.inst[31]}}, f.inst[19:12], f.inst[20], f.inst[30:21], 1'b0};
    imm_u  = {f.inst[31:12], 12'b0};
    value  = '0;
    writes = 1'b1;
    taken  = 1'b0;
    r.pc      = f.pc;
    r.next_pc = f.pc + 32'd4;
    case (f.inst[6:0])
      rv_isa_pkg::op_reg:   value = alu_calc(f3, f.inst[30], a, b);
      rv_isa_pkg::op_imm:   value = alu_calc(f3, f3 == 3'd5 && f.inst[30], a, imm_i);
      rv_isa_pkg::op_lui:   value = imm_u;
      rv_isa_pkg::op_auipc: value = f.pc + imm_u;
      rv_isa_pkg::op_jal: begin
        value     = f.pc + 32'd4;
        r.next_pc = f.pc + imm_j;
      end
      rv_isa_pkg::op_jalr: begin
        value     = f.pc + 32'd4;
        r.next_pc = (a + imm_i) & ~32'd1;
      end
      rv_isa_pkg::op_branch: begin
        writes = 1'b0;
        case (f3)
          3'd0: taken = a == b;
          3'd1: taken = a != b;
          3'd4: taken = $signed(a) < $signed(b);
          3'd5: taken = $signed(a) >= $signed(b);
          3'd6: taken = a < b;
          3'd7: taken = a >= b;
          default: taken = 1'b0;
        endcase
        if (taken) r.next_pc = f.pc + imm_b;
      end
      default: writes = 1'b0;  // Unsupported opcodes do nothing.
    endcase
    r.rd_addr = writes ? f.inst[11:7] : 5'd0;
    r.wb      = writes && f.inst[11:7] != 5'd0;
    r.wdata   = r.wb ? value : '0;
    return r;
  endfunction

  // ####################
  // Stimulus
  // ####################
  function automatic logic [31:0] pick_operand();
    case ($random(seed) & 7)
      0: return 32'h0000_0000;
      1: return 32'h7fff_ffff;
      2: return 32'h8000_0000;
      3: return 32'hffff_ffff;
      4: return 32'h0000_0001;
      default: return $random(seed);
    endcase
  endfunction

  function automatic pipe_pkg::fetch_t random_fetch();
    pipe_pkg::fetch_t f;
    rv_isa_pkg::inst_u iw;
    logic [6:0] unknown_ops [4];
    unknown_ops = '{7'b0000011, 7'b0100011, 7'b1110011, 7'b0001111};
    iw = $random(seed);
    case ($unsigned($random(seed)) % 9)
      0: begin
        iw.r.opcode = rv_isa_pkg::op_reg;
        iw.r.funct7 = {1'b0, iw.r.funct7[5], 5'b0};
      end
      1: iw.i.opcode = rv_isa_pkg::op_imm;
      2: iw.u.opcode = rv_isa_pkg::op_lui;
      3: iw.u.opcode = rv_isa_pkg::op_auipc;
      4: iw.j.opcode = rv_isa_pkg::op_jal;
      5: begin
        iw.i.opcode = rv_isa_pkg::op_jalr;
        iw.i.funct3 = 3'b000;
      end
      6, 7: begin
        iw.b.opcode = rv_isa_pkg::op_branch;
        if (iw.b.funct3 inside {3'b010, 3'b011}) iw.b.funct3[1] = 1'b0;
      end
      default: iw.r.opcode = unknown_ops[$random(seed) & 3];
    endcase
    if (($random(seed) & 7) == 0) iw.r.rd = 5'd0;
    f.pc       = $random(seed) & ~32'd3;
    f.inst     = iw;
    f.rs1_data = pick_operand();
    f.rs2_data = pick_operand();
    if (($random(seed) & 3) == 0) f.rs2_data = f.rs1_data;  // Equal operands for beq.
    return f;
  endfunction

  // One cycle, ending at the falling edge with retire_ready driven.
  task automatic step();
    pipe_pkg::retire_t want;
    @(negedge clock);
    retire_ready = ($random(seed) & 3) != 0;
    assert (dut.u_assert.errors == 0) else stop_run("a bound handshake assertion failed");
    if (retire_valid && retire_ready) begin
      assert (expected_q.size() != 0) else stop_run("a record retired with nothing outstanding");
      want = expected_q.pop_front();
      assert (retire == want)
        else stop_run($sformatf({"[FAIL] %0t: retire pc %h next_pc %h wdata %h rd %0d wb %b,",
                                 " expected pc %h next_pc %h wdata %h rd %0d wb %b"},
                                $time, retire.pc, retire.next_pc, retire.wdata,
                                retire.rd_addr, retire.wb, want.pc, want.next_pc,
                                want.wdata, want.rd_addr, want.wb));
      retired++;
    end
  endtask

  task automatic send(input pipe_pkg::fetch_t f);
    fetch       = f;
    fetch_valid = 1'b1;
    while (!fetch_ready) step();
    expected_q.push_back(expected_retire(f));  // Transfer lands on the next rising edge.
    step();
    fetch_valid = 1'b0;
  endtask

  initial begin
    seed         = 95;
    retired      = 0;
    reset        = 1'b1;
    fetch        = '0;
    fetch_valid  = 1'b0;
    retire_ready = 1'b0;
    repeat (2) @(negedge clock);
    reset = 1'b0;
    for (int n = 0; n < n_inst; n++) begin
      if (($random(seed) & 7) == 0) repeat (8) step();  // Lets the pipeline drain.
      send(random_fetch());
    end
    while (retired < n_inst) step();
    repeat (2) step();
    if (expected_q.size() == 0 && dut.u_assert.errors == 0) begin
      $display("*** TEST PASSED ***");
      $finish;
    end else begin
      stop_run("records left outstanding or a bound assertion failed at the end");
    end
  end

endmodule

// ==== sim.f ====
logic/rv_isa_pkg.sv
logic/pipe_pkg.sv
logic/alu.sv
logic/idu.sv
logic/exu.sv
logic/commit_unit.sv
logic/rv_exec_top.sv
verif/rv_exec_assert.sv
verif/rv_exec_tb.sv

// ==== Bender.yml ====
package:
  name: rv_exec

sources:
  - logic/rv_isa_pkg.sv
  - logic/pipe_pkg.sv
  - logic/alu.sv
  - logic/idu.sv
  - logic/exu.sv
  - logic/commit_unit.sv
  - logic/rv_exec_top.sv
  - target: test
    files:
      - verif/rv_exec_assert.sv
      - verif/rv_exec_tb.sv
